//--- common/mp4_mem_pkg.sv
package mp4_mem_pkg;

    typedef logic [31:0]  rv32i_word;
    typedef logic [255:0] rv32i_cacheline;
    typedef logic [63:0]  burst_t;    // one beat on the memory bus

    // cache geometry, tag + index + offset span the whole word
    localparam int NUM_SETS    = 8;
    localparam int OFFSET_BITS = 5;   // 32 bytes per line
    localparam int INDEX_BITS  = 3;
    localparam int TAG_BITS    = 24;
    localparam int BURST_BEATS = 4;   // 64-bit beats per line

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL,
        RESPOND
    } cache_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ICACHE,
        ARB_DCACHE
    } arb_state_e;

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_READ,
        AD_WRITE,
        AD_DONE
    } adapt_state_e;

endpackage : mp4_mem_pkg

//--- common/line_if.sv
`timescale 1ns/1ps

interface line_if;
    import mp4_mem_pkg::*;

    rv32i_word      address;    // line aligned
    logic           read;
    logic           write;
    rv32i_cacheline wdata;
    rv32i_cacheline rdata;
    logic           resp;       // single cycle pulse

    // requester side
    modport cache (output address, read, write, wdata, input rdata, resp);

    // responder side, as seen by the arbiter
    modport arb (input address, read, write, wdata, output rdata, resp);

    // responder side toward the burst memory
    modport adapt (input address, read, write, wdata, output rdata, resp);

endinterface : line_if

//--- hw/cache/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mp4_mem_pkg::rv32i_word mem_address_i,
    input  logic                   mem_read_i,
    output mp4_mem_pkg::rv32i_word mem_rdata_o,
    output logic                   mem_resp_o,
    line_if.cache                  line
);
    import mp4_mem_pkg::*;

    cache_state_e          state_q;
    logic [TAG_BITS-1:0]   tag_q [NUM_SETS];
    rv32i_cacheline        data_q [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;
    logic                  resp_q;
    rv32i_word             rdata_q;

    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  idx;
    logic [OFFSET_BITS-3:0] word_sel;    // word within the line
    logic                   hit;
    logic                   access;

    assign tag      = mem_address_i[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign idx      = mem_address_i[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = mem_address_i[OFFSET_BITS-1:2];

    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // resp_q high means the current request was just answered
    assign access = mem_read_i && hit && !resp_q &&
                    ((state_q == IDLE) || (state_q == RESPOND));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            resp_q <= access;
            case (state_q)
                IDLE: begin
                    if (mem_read_i && !hit && !resp_q)
                        state_q <= FILL;
                end
                FILL: begin
                    if (line.resp) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;   // word goes out here
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == FILL) && line.resp) begin
            data_q[idx] <= line.rdata;
            tag_q[idx]  <= tag;
        end
        if (access)
            rdata_q <= data_q[idx][word_sel*32 +: 32];
    end

    assign mem_rdata_o = rdata_q;
    assign mem_resp_o  = resp_q;

    // read only, never writes a line back
    assign line.address = {tag, idx, {OFFSET_BITS{1'b0}}};
    assign line.read    = (state_q == FILL);
    assign line.write   = 1'b0;
    assign line.wdata   = '0;

endmodule : icache

//--- hw/cache/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mp4_mem_pkg::rv32i_word mem_address_i,
    input  logic                   mem_read_i,
    input  logic                   mem_write_i,
    input  logic [3:0]             mem_wmask_i,
    input  mp4_mem_pkg::rv32i_word mem_wdata_i,
    output mp4_mem_pkg::rv32i_word mem_rdata_o,
    output logic                   mem_resp_o,
    line_if.cache                  line
);
    import mp4_mem_pkg::*;

    cache_state_e          state_q;
    logic [TAG_BITS-1:0]   tag_q [NUM_SETS];
    rv32i_cacheline        data_q [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;
    logic [NUM_SETS-1:0]   dirty_q;
    logic                  resp_q;
    rv32i_word             rdata_q;

    logic [TAG_BITS-1:0]      tag;
    logic [INDEX_BITS-1:0]    idx;
    logic [OFFSET_BITS-3:0]   word_sel;
    logic                     req;
    logic                     hit;
    logic                     access;
    logic [2**OFFSET_BITS-1:0] line_be;     // byte enables across the line
    rv32i_cacheline           merged_line;

    assign tag      = mem_address_i[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign idx      = mem_address_i[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = mem_address_i[OFFSET_BITS-1:2];

    assign req = mem_read_i || mem_write_i;
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // a request is served once, resp_q blocks the cycle it is answered in
    assign access = req && hit && !resp_q &&
                    ((state_q == IDLE) || (state_q == RESPOND));

    // place the mask at the word offset, then take only enabled bytes
    always_comb begin
        line_be = '0;
        line_be[word_sel*4 +: 4] = mem_wmask_i;
        for (int b = 0; b < 2**OFFSET_BITS; b++) begin
            if (line_be[b])
                merged_line[b*8 +: 8] = mem_wdata_i[(b%4)*8 +: 8];
            else
                merged_line[b*8 +: 8] = data_q[idx][b*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= access;
            case (state_q)
                IDLE: begin
                    if (req && !hit && !resp_q) begin
                        if (valid_q[idx] && dirty_q[idx])
                            state_q <= WRITEBACK;   // old line goes out first
                        else
                            state_q <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (line.resp)
                        state_q <= FILL;
                end
                FILL: begin
                    if (line.resp) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                        state_q      <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
            if (access && mem_write_i)
                dirty_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == FILL) && line.resp) begin
            data_q[idx] <= line.rdata;
            tag_q[idx]  <= tag;
        end else if (access && mem_write_i) begin
            data_q[idx] <= merged_line;
        end
        if (access)
            rdata_q <= data_q[idx][word_sel*32 +: 32];  // pre-store value on writes
    end

    assign mem_rdata_o = rdata_q;
    assign mem_resp_o  = resp_q;

    // writeback targets the address of the resident tag
    assign line.address = (state_q == WRITEBACK) ? {tag_q[idx], idx, {OFFSET_BITS{1'b0}}}
                                                 : {tag, idx, {OFFSET_BITS{1'b0}}};
    assign line.read    = (state_q == FILL);
    assign line.write   = (state_q == WRITEBACK);
    assign line.wdata   = data_q[idx];

endmodule : dcache

//--- hw/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic  clk,
    input  logic  arst_n_i,
    line_if.arb   icache_line,
    line_if.arb   dcache_line,
    line_if.cache mem_line
);
    import mp4_mem_pkg::*;

    arb_state_e state_q;
    logic       icache_req;
    logic       dcache_req;
    logic       sel_dcache;    // current grant, valid in idle too

    assign icache_req = icache_line.read || icache_line.write;
    assign dcache_req = dcache_line.read || dcache_line.write;

    // grant resolves combinationally in idle so no cycle is lost
    always_comb begin
        case (state_q)
            ARB_IDLE:   sel_dcache = dcache_req;   // dcache wins a tie
            ARB_DCACHE: sel_dcache = 1'b1;
            default:    sel_dcache = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (dcache_req)
                        state_q <= ARB_DCACHE;
                    else if (icache_req)
                        state_q <= ARB_ICACHE;
                end
                ARB_ICACHE,
                ARB_DCACHE: begin
                    if (mem_line.resp)
                        state_q <= ARB_IDLE;     // held until the line comes back
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    assign mem_line.address = sel_dcache ? dcache_line.address : icache_line.address;
    assign mem_line.read    = sel_dcache ? dcache_line.read    : icache_line.read;
    assign mem_line.write   = sel_dcache ? dcache_line.write   : icache_line.write;
    assign mem_line.wdata   = sel_dcache ? dcache_line.wdata   : icache_line.wdata;

    // only the granted cache sees the response
    assign icache_line.rdata = sel_dcache ? '0 : mem_line.rdata;
    assign dcache_line.rdata = sel_dcache ? mem_line.rdata : '0;
    assign icache_line.resp  = mem_line.resp && !sel_dcache;
    assign dcache_line.resp  = mem_line.resp && sel_dcache;

endmodule : cache_arbiter

//--- hw/cacheline_adaptor.sv
`timescale 1ns/1ps

module cacheline_adaptor (
    input  logic                   clk,
    input  logic                   arst_n_i,
    line_if.adapt                  line,
    output mp4_mem_pkg::rv32i_word bmem_address_o,
    output logic                   bmem_read_o,
    output logic                   bmem_write_o,
    input  mp4_mem_pkg::burst_t    bmem_rdata_i,
    output mp4_mem_pkg::burst_t    bmem_wdata_o,
    input  logic                   bmem_resp_i
);
    import mp4_mem_pkg::*;

    localparam int LINE_W  = $bits(rv32i_cacheline);
    localparam int BURST_W = $bits(burst_t);

    adapt_state_e                   state_q;
    logic [$clog2(BURST_BEATS)-1:0] beat_q;
    rv32i_cacheline                 buf_q;     // shift register, beat 0 lowest
    rv32i_word                      addr_q;
    logic                           busy;
    logic                           last_beat;

    assign busy      = (state_q == AD_READ) || (state_q == AD_WRITE);
    assign last_beat = bmem_resp_i && (int'(beat_q) == BURST_BEATS - 1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= AD_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                AD_IDLE: begin
                    beat_q <= '0;
                    if (line.read)
                        state_q <= AD_READ;
                    else if (line.write)
                        state_q <= AD_WRITE;
                end
                AD_READ,
                AD_WRITE: begin
                    if (bmem_resp_i)
                        beat_q <= beat_q + 1'b1;
                    if (last_beat)
                        state_q <= AD_DONE;
                end
                AD_DONE: state_q <= AD_IDLE;   // line resp pulse
                default: state_q <= AD_IDLE;
            endcase
        end
    end

    // reads shift in at the top, writes shift out at the bottom
    always_ff @(posedge clk) begin
        if (state_q == AD_IDLE) begin
            addr_q <= line.address;
            buf_q  <= line.wdata;
        end else if (busy && bmem_resp_i) begin
            buf_q <= {bmem_rdata_i, buf_q[LINE_W-1:BURST_W]};
        end
    end

    assign bmem_address_o = addr_q;
    assign bmem_read_o    = (state_q == AD_READ);
    assign bmem_write_o   = (state_q == AD_WRITE);
    assign bmem_wdata_o   = buf_q[BURST_W-1:0];

    assign line.rdata = buf_q;
    assign line.resp  = (state_q == AD_DONE);

endmodule : cacheline_adaptor

//--- hw/mp4_mem.sv
`timescale 1ns/1ps

module mp4_mem (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // instruction fetch port
    input  mp4_mem_pkg::rv32i_word imem_address_i,
    input  logic                   imem_read_i,
    output mp4_mem_pkg::rv32i_word imem_rdata_o,
    output logic                   imem_resp_o,
    // data load/store port
    input  mp4_mem_pkg::rv32i_word dmem_address_i,
    input  logic                   dmem_read_i,
    input  logic                   dmem_write_i,
    input  logic [3:0]             dmem_wmask_i,
    input  mp4_mem_pkg::rv32i_word dmem_wdata_i,
    output mp4_mem_pkg::rv32i_word dmem_rdata_o,
    output logic                   dmem_resp_o,
    // burst memory
    output mp4_mem_pkg::rv32i_word bmem_address_o,
    output logic                   bmem_read_o,
    output logic                   bmem_write_o,
    input  mp4_mem_pkg::burst_t    bmem_rdata_i,
    output mp4_mem_pkg::burst_t    bmem_wdata_o,
    input  logic                   bmem_resp_i
);

    line_if icache_line ();
    line_if dcache_line ();
    line_if mem_line ();    // arbiter to adaptor

    icache icache0 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .mem_address_i (imem_address_i),
        .mem_read_i    (imem_read_i),
        .mem_rdata_o   (imem_rdata_o),
        .mem_resp_o    (imem_resp_o),
        .line          (icache_line.cache)
    );

    dcache dcache0 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .mem_address_i (dmem_address_i),
        .mem_read_i    (dmem_read_i),
        .mem_write_i   (dmem_write_i),
        .mem_wmask_i   (dmem_wmask_i),
        .mem_wdata_i   (dmem_wdata_i),
        .mem_rdata_o   (dmem_rdata_o),
        .mem_resp_o    (dmem_resp_o),
        .line          (dcache_line.cache)
    );

    cache_arbiter cache_arbiter0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .icache_line (icache_line.arb),
        .dcache_line (dcache_line.arb),
        .mem_line    (mem_line.cache)
    );

    cacheline_adaptor cacheline_adaptor0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .line           (mem_line.adapt),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mp4_mem

//--- dv/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mp4_mem_pkg::rv32i_word address_i,
    input  logic                   read_i,
    input  logic                   write_i,
    input  mp4_mem_pkg::burst_t    wdata_i,
    output mp4_mem_pkg::burst_t    rdata_o,
    output logic                   resp_o
);
    import mp4_mem_pkg::*;

    localparam int LATENCY = 6;    // cycles from request to first beat

    rv32i_word words [rv32i_word];  // only words written so far
    rv32i_word line_base;
    int        count_q;
    int        beat_q;              // beat currently on the bus
    int        next_beat;

    assign line_base = {address_i[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // untouched words hold their byte address with a marker in the upper half
    function automatic rv32i_word peek(input rv32i_word addr);
        if (words.exists(addr))
            return words[addr];
        return addr ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= 0;
            beat_q  <= 0;
            resp_o  <= 1'b0;
            rdata_o <= '0;
        end else if (!read_i && !write_i) begin
            count_q <= 0;
            beat_q  <= 0;
            resp_o  <= 1'b0;
        end else begin
            if (resp_o && write_i) begin
                words[line_base + beat_q*8]     = wdata_i[31:0];
                words[line_base + beat_q*8 + 4] = wdata_i[63:32];
            end
            next_beat = resp_o ? beat_q + 1 : beat_q;
            beat_q <= next_beat;
            if (count_q < LATENCY)
                count_q <= count_q + 1;
            resp_o  <= (count_q >= LATENCY - 1) && (next_beat < BURST_BEATS);
            rdata_o <= {peek(line_base + next_beat*8 + 4), peek(line_base + next_beat*8)};
        end
    end

endmodule : burst_mem_model

//--- dv/mp4_mem_tb.sv
`timescale 1ns/1ps

module mp4_mem_tb;
    import mp4_mem_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_WAIT    = 100;   // cycles per request

    logic       clk;
    logic       arst_n;
    rv32i_word  imem_address;
    logic       imem_read;
    rv32i_word  imem_rdata;
    logic       imem_resp;
    rv32i_word  dmem_address;
    logic       dmem_read;
    logic       dmem_write;
    logic [3:0] dmem_wmask;
    rv32i_word  dmem_wdata;
    rv32i_word  dmem_rdata;
    logic       dmem_resp;
    rv32i_word  bmem_address;
    logic       bmem_read;
    logic       bmem_write;
    burst_t     bmem_rdata;
    burst_t     bmem_wdata;
    logic       bmem_resp;

    rv32i_word shadow [rv32i_word];     // every word stored so far
    rv32i_word exp_imem;
    rv32i_word exp_dmem;
    string     test_name;
    integer    seed;
    int        error_count;
    int        errors_at_start;
    int        tests_failed;
    int        write_cycles;
    logic      quiet;                   // high while only hits are expected

    mp4_mem dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .imem_address_i (imem_address),
        .imem_read_i    (imem_read),
        .imem_rdata_o   (imem_rdata),
        .imem_resp_o    (imem_resp),
        .dmem_address_i (dmem_address),
        .dmem_read_i    (dmem_read),
        .dmem_write_i   (dmem_write),
        .dmem_wmask_i   (dmem_wmask),
        .dmem_wdata_i   (dmem_wdata),
        .dmem_rdata_o   (dmem_rdata),
        .dmem_resp_o    (dmem_resp),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_resp_i    (bmem_resp)
    );

    burst_mem_model mem_model0 (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .address_i (bmem_address),
        .read_i    (bmem_read),
        .write_i   (bmem_write),
        .wdata_i   (bmem_wdata),
        .rdata_o   (bmem_rdata),
        .resp_o    (bmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (bmem_write)
            write_cycles <= write_cycles + 1;
    end

    imem_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        imem_resp |-> imem_rdata == exp_imem)
    else begin
        error_count++;
        $display("ERROR %s: imem %h expected %h actual %h", test_name, imem_address,
                 exp_imem, imem_rdata);
    end

    dmem_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_resp && dmem_read) |-> dmem_rdata == exp_dmem)
    else begin
        error_count++;
        $display("ERROR %s: dmem %h expected %h actual %h", test_name, dmem_address,
                 exp_dmem, dmem_rdata);
    end

    // each response lasts a single cycle
    resp_pulse_check: assert property (@(posedge clk) disable iff (!arst_n)
        (imem_resp |=> !imem_resp) and (dmem_resp |=> !dmem_resp))
    else begin
        error_count++;
        $display("%s: a cpu response stayed high for more than one cycle", test_name);
    end

    bmem_hold_check: assert property (@(posedge clk) disable iff (!arst_n)
        ((bmem_read || bmem_write) && !bmem_resp) |=> (bmem_read || bmem_write))
    else begin
        error_count++;
        $display("%s: bmem strobe dropped before its last beat", test_name);
    end

    quiet_check: assert property (@(posedge clk) disable iff (!arst_n)
        quiet |-> (!bmem_read && !bmem_write))
    else begin
        error_count++;
        $display("%s: memory traffic seen while every access should hit", test_name);
    end

    function automatic rv32i_word expected_word(input rv32i_word addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic rv32i_word merge_bytes(input rv32i_word old_word,
                                              input rv32i_word data,
                                              input logic [3:0] mask);
        rv32i_word merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                merged[b*8 +: 8] = data[b*8 +: 8];
        end
        return merged;
    endfunction

    function automatic rv32i_word random_word_addr();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // returns one cycle after resp so the caller can drop the request
    task automatic wait_resp(input bit data_port);
        int   waited;
        logic got;
        waited = 0;
        @(negedge clk);
        got = data_port ? dmem_resp : imem_resp;
        while (!got && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
            got = data_port ? dmem_resp : imem_resp;
        end
        if (!got) begin
            error_count++;
            $display("%s: no %s response within %0d cycles", test_name,
                     data_port ? "dmem" : "imem", MAX_WAIT);
        end
        next_cycle();
    endtask

    task automatic fetch(input rv32i_word addr);
        next_cycle();
        imem_address = addr;
        imem_read    = 1'b1;
        exp_imem     = expected_word(addr);
        wait_resp(1'b0);
        imem_read = 1'b0;
    endtask

    task automatic load(input rv32i_word addr);
        next_cycle();
        dmem_address = addr;
        dmem_read    = 1'b1;
        exp_dmem     = expected_word(addr);
        wait_resp(1'b1);
        dmem_read = 1'b0;
    endtask

    task automatic store(input rv32i_word addr, input rv32i_word data,
                         input logic [3:0] mask);
        next_cycle();
        dmem_address = addr;
        dmem_wdata   = data;
        dmem_wmask   = mask;
        dmem_write   = 1'b1;
        shadow[addr] = merge_bytes(expected_word(addr), data, mask);
        wait_resp(1'b1);
        dmem_write = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    initial begin
        rv32i_word a;
        rv32i_word b;
        int        writes_before;
        seed         = 32'habc0;
        error_count  = 0;
        tests_failed = 0;
        write_cycles = 0;
        quiet        = 1'b0;
        test_name    = "reset";
        exp_imem     = '0;
        exp_dmem     = '0;
        imem_address = '0;
        imem_read    = 1'b0;
        dmem_address = '0;
        dmem_read    = 1'b0;
        dmem_write   = 1'b0;
        dmem_wmask   = '0;
        dmem_wdata   = '0;
        arst_n       = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        start_test("imem_miss");
        a = random_word_addr();
        fetch(a);
        fetch(a ^ 32'h10);          // other word in the same line
        finish_test();

        start_test("hit_no_traffic");
        a = random_word_addr();
        b = random_word_addr();
        fetch(a);
        load(b);
        quiet = 1'b1;
        repeat (4) begin
            fetch(a);
            load(b);
        end
        fetch(a ^ 32'h4);
        quiet = 1'b0;
        finish_test();

        start_test("byte_store");
        a = random_word_addr();
        load(a);
        store(a, $random(seed), 4'b0101);
        load(a);
        store(a, $random(seed), 4'b1000);
        load(a);
        finish_test();

        start_test("dirty_evict");
        a = random_word_addr();
        b = a ^ ((random_word_addr() & 32'hffff_ff00) | 32'h100);  // same index with a new tag
        store(a, $random(seed), 4'b1111);
        writes_before = write_cycles;
        load(b);
        assert (write_cycles > writes_before)
        else begin
            error_count++;
            $display("%s: no bmem write seen during the eviction", test_name);
        end
        load(a);
        finish_test();

        start_test("concurrent_miss");
        a = random_word_addr();
        b = random_word_addr();
        fork
            fetch(a);
            load(b);
        join
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, error_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, run aborted", NUM_TESTS * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule : mp4_mem_tb

//--- mp4_mem.f
common/mp4_mem_pkg.sv
common/line_if.sv
hw/cache/icache.sv
hw/cache/dcache.sv
hw/cache_arbiter.sv
hw/cacheline_adaptor.sv
hw/mp4_mem.sv
dv/burst_mem_model.sv
dv/mp4_mem_tb.sv
